// ==== Bender.yml ====
package:
  name: cl_ddr_stat

sources:
  - files:
      - rtl/ddr_stat_pkg.sv
      - rtl/ddr_stat_if.sv
      - rtl/lib_pipe.sv
      - rtl/ddr_stat_regs.sv
      - rtl/cl_ddr_stat_top.sv
  - target: test
    files:
      - verification/tb_cl_ddr_stat_top.sv

// ==== build.f ====
rtl/ddr_stat_pkg.sv
rtl/ddr_stat_if.sv
rtl/lib_pipe.sv
rtl/ddr_stat_regs.sv
rtl/cl_ddr_stat_top.sv
verification/tb_cl_ddr_stat_top.sv

// ==== rtl/cl_ddr_stat_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// DDR status bus side of the custom logic, one pipeline pair per channel
module cl_ddr_stat_top #(
   parameter int unsigned NUM_DDR_CH = 3,
   parameter int unsigned CFG_STAGES = 8,
   parameter int unsigned RST_STAGES = 4
)(
   input  logic                     clk_main_a0,
   input  logic                     pipe_rst_n,

   // Shell to DDR status requests
   input  logic [NUM_DDR_CH-1:0]    sh_ddr_stat_wr,
   input  logic [NUM_DDR_CH-1:0]    sh_ddr_stat_rd,
   input  ddr_stat_pkg::stat_addr_t sh_ddr_stat_addr  [NUM_DDR_CH],
   input  ddr_stat_pkg::stat_data_t sh_ddr_stat_wdata [NUM_DDR_CH],

   // DDR status acknowledges back to the shell
   output logic [NUM_DDR_CH-1:0]    ddr_sh_stat_ack,
   output ddr_stat_pkg::stat_data_t ddr_sh_stat_rdata [NUM_DDR_CH],
   output ddr_stat_pkg::stat_int_t  ddr_sh_stat_int   [NUM_DDR_CH]
);
   import ddr_stat_pkg::*;

   localparam int unsigned REQ_W = 1 + 1 + $bits(stat_addr_t) + $bits(stat_data_t);
   localparam int unsigned ACK_W = 1 + $bits(stat_int_t) + $bits(stat_data_t);

   genvar ch;

   generate
      for (ch = 0; ch < NUM_DDR_CH; ch++)
      begin : g_ch
         logic             slc_rst_n;
         logic [REQ_W-1:0] req_q;
         logic [ACK_W-1:0] ack_q;

         ddr_stat_if stat_bus ();

         // ---------------------------------------------------------------------
         // Reset slice for the target
         // ---------------------------------------------------------------------
         lib_pipe #(
            .WIDTH     (1),
            .STAGES    (RST_STAGES),
            .HAS_RESET (1'b0)
         ) u_rst_slc (
            .clk_main_a0 (clk_main_a0),
            .pipe_rst_n  (1'b1),
            .in_bus      (pipe_rst_n),
            .out_bus     (slc_rst_n)
         );

         // ---------------------------------------------------------------------
         // Request pipeline toward the target
         // ---------------------------------------------------------------------
         lib_pipe #(
            .WIDTH     (REQ_W),
            .STAGES    (CFG_STAGES),
            .HAS_RESET (1'b1)
         ) u_req_pipe (
            .clk_main_a0 (clk_main_a0),
            .pipe_rst_n  (pipe_rst_n),
            .in_bus      ({sh_ddr_stat_wr[ch], sh_ddr_stat_rd[ch],
                           sh_ddr_stat_addr[ch], sh_ddr_stat_wdata[ch]}),
            .out_bus     (req_q)
         );

         assign {stat_bus.wr, stat_bus.rd, stat_bus.addr, stat_bus.wdata} = req_q;

         // Stand-in for the controller status port
         ddr_stat_regs #(
            .CH_ID (ch)
         ) u_stat_regs (
            .clk_main_a0 (clk_main_a0),
            .pipe_rst_n  (slc_rst_n),
            .stat        (stat_bus.ddr)
         );

         // ---------------------------------------------------------------------
         // Acknowledge pipeline back to the shell
         // ---------------------------------------------------------------------
         lib_pipe #(
            .WIDTH     (ACK_W),
            .STAGES    (CFG_STAGES),
            .HAS_RESET (1'b1)
         ) u_ack_pipe (
            .clk_main_a0 (clk_main_a0),
            .pipe_rst_n  (pipe_rst_n),
            .in_bus      ({stat_bus.ack, stat_bus.intr, stat_bus.rdata}),
            .out_bus     (ack_q)
         );

         assign {ddr_sh_stat_ack[ch], ddr_sh_stat_int[ch], ddr_sh_stat_rdata[ch]} = ack_q;
      end
   endgenerate

endmodule

`default_nettype wire

// ==== rtl/ddr_stat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One channel of the DDR status bus
interface ddr_stat_if;
   import ddr_stat_pkg::*;

   // Request side, single-cycle pulse on wr or rd
   logic       wr;
   logic       rd;
   stat_addr_t addr;
   stat_data_t wdata;

   // Acknowledge side, ack is one cycle after the request
   logic       ack;
   stat_data_t rdata;
   stat_int_t  intr;

   // Requester end of the bus
   modport shell (
      output wr, rd, addr, wdata,
      input  ack, rdata, intr
   );

   // Status register target end
   modport ddr (
      input  wr, rd, addr, wdata,
      output ack, rdata, intr
   );

endinterface

`default_nettype wire

// ==== rtl/ddr_stat_pkg.sv ====
`default_nettype none

package ddr_stat_pkg;

   // -------------------------------------------------------------------------
   // Status bus field types
   // -------------------------------------------------------------------------
   typedef logic [7:0]  stat_addr_t;
   typedef logic [31:0] stat_data_t;
   typedef logic [7:0]  stat_int_t;

   // -------------------------------------------------------------------------
   // Register map
   // -------------------------------------------------------------------------

   // Scratch words occupy 0x00 up to this address
   localparam stat_addr_t STAT_SCRATCH_LAST = 8'h0F;

   // Read-only channel number
   localparam stat_addr_t STAT_ADDR_CH_ID   = 8'h10;

   // Write ORs bits in, read returns the interrupt register
   localparam stat_addr_t STAT_ADDR_INT_SET = 8'h11;

   // Write clears bits, read returns zero
   localparam stat_addr_t STAT_ADDR_INT_CLR = 8'h12;

   // Returned for reads of unmapped addresses
   localparam stat_data_t STAT_BAD_RDATA    = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// ==== rtl/ddr_stat_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Status register target for one DDR channel
module ddr_stat_regs #(
   parameter int unsigned CH_ID = 0
)(
   input  logic   clk_main_a0,
   input  logic   pipe_rst_n,
   ddr_stat_if.ddr stat
);
   import ddr_stat_pkg::*;

   localparam int unsigned NUM_SCRATCH = STAT_SCRATCH_LAST + 1;
   localparam int unsigned SCRATCH_AW  = $clog2(NUM_SCRATCH);

   stat_data_t              scratch [NUM_SCRATCH];
   stat_int_t               int_q;
   stat_int_t               int_nxt;
   stat_int_t               set_bits;
   stat_int_t               clr_bits;
   logic                    ack_q;
   stat_data_t              rdata_q;
   stat_data_t              rdata_nxt;
   logic                    is_scratch;
   logic [SCRATCH_AW-1:0]   scratch_idx;

   // --------------------------------------------------------------------------
   // Address decode
   // --------------------------------------------------------------------------
   assign is_scratch  = (stat.addr <= STAT_SCRATCH_LAST);
   assign scratch_idx = stat.addr[SCRATCH_AW-1:0];

   always_comb
   begin
      rdata_nxt = '0;
      set_bits  = '0;
      clr_bits  = '0;

      // Read data is zero unless this cycle carries a read
      if (stat.rd)
      begin
         if (is_scratch)
            rdata_nxt = scratch[scratch_idx];
         else if (stat.addr == STAT_ADDR_CH_ID)
            rdata_nxt = stat_data_t'(CH_ID);
         else if (stat.addr == STAT_ADDR_INT_SET)
            rdata_nxt = stat_data_t'(int_q);
         else if (stat.addr == STAT_ADDR_INT_CLR)
            rdata_nxt = '0;
         else
            rdata_nxt = STAT_BAD_RDATA;
      end

      if (stat.wr && (stat.addr == STAT_ADDR_INT_SET))
         set_bits = stat.wdata[$bits(stat_int_t)-1:0];
      if (stat.wr && (stat.addr == STAT_ADDR_INT_CLR))
         clr_bits = stat.wdata[$bits(stat_int_t)-1:0];
   end

   // Clear wins over set when both land together
   assign int_nxt = (int_q | set_bits) & ~clr_bits;

   // --------------------------------------------------------------------------
   // Registers
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
      begin
         for (int i = 0; i < NUM_SCRATCH; i++)
            scratch[i] <= '0;
         int_q <= '0;
         ack_q <= 1'b0;
      end
      else
      begin
         if (stat.wr && is_scratch)
            scratch[scratch_idx] <= stat.wdata;
         int_q <= int_nxt;
         // One ack per request, writes to unmapped space included
         ack_q <= stat.wr | stat.rd;
      end
   end

   // Read data follows the request every cycle
   always_ff @(posedge clk_main_a0)
   begin
      rdata_q <= rdata_nxt;
   end

   assign stat.ack   = ack_q;
   assign stat.rdata = rdata_q;
   assign stat.intr  = int_q;

   // --------------------------------------------------------------------------
   // Protocol checks
   // --------------------------------------------------------------------------
   a_wr_rd_excl: assert property (@(posedge clk_main_a0) disable iff (!pipe_rst_n)
      !(stat.wr && stat.rd))
      else $error("wr and rd high together");

   a_req_ack: assert property (@(posedge clk_main_a0) disable iff (!pipe_rst_n)
      (stat.wr || stat.rd) |=> stat.ack)
      else $error("request without ack on the next cycle");

   a_ack_req: assert property (@(posedge clk_main_a0) disable iff (!pipe_rst_n)
      stat.ack |-> $past(stat.wr || stat.rd))
      else $error("ack without a request on the cycle before");

endmodule

`default_nettype wire

// ==== rtl/lib_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

// Register chain used to close timing over long routes
module lib_pipe #(
   parameter int unsigned WIDTH     = 1,
   parameter int unsigned STAGES    = 1,
   parameter bit          HAS_RESET = 1'b0
)(
   input  logic             clk_main_a0,
   input  logic             pipe_rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   generate
      if (STAGES == 0)
      begin : g_bypass
         // No stages, straight wire
         assign out_bus = in_bus;
      end
      else
      begin : g_stages
         logic [WIDTH-1:0] pipe_q [STAGES];

         always_ff @(posedge clk_main_a0)
         begin
            if (HAS_RESET && !pipe_rst_n)
            begin
               for (int i = 0; i < STAGES; i++)
                  pipe_q[i] <= '0;
            end
            else
            begin
               pipe_q[0] <= in_bus;
               // Shift toward the output end
               for (int i = 1; i < STAGES; i++)
                  pipe_q[i] <= pipe_q[i-1];
            end
         end

         assign out_bus = pipe_q[STAGES-1];
      end
   endgenerate

endmodule

`default_nettype wire

// ==== verification/tb_cl_ddr_stat_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cl_ddr_stat_top;

   localparam int NUM_CH    = 3;
   localparam int LATENCY   = 17;
   localparam int BURST_LEN = 12;

   localparam logic [1:0] OP_IDLE = 2'd0;
   localparam logic [1:0] OP_WR   = 2'd1;
   localparam logic [1:0] OP_RD   = 2'd2;

   // One stimulus step with its expected response
   typedef struct packed {
      logic [1:0]  ch;
      logic [1:0]  op;
      logic [7:0]  addr;
      logic [31:0] wdata;
      logic [31:0] exp_rdata;
      logic [7:0]  exp_int;
   } entry_t;

   logic              clk_main_a0;
   logic              pipe_rst_n;
   logic [NUM_CH-1:0] stat_wr;
   logic [NUM_CH-1:0] stat_rd;
   logic [7:0]        stat_addr  [NUM_CH];
   logic [31:0]       stat_wdata [NUM_CH];
   logic [NUM_CH-1:0] stat_ack;
   logic [31:0]       stat_rdata [NUM_CH];
   logic [7:0]        stat_int   [NUM_CH];

   entry_t stim_q [$];
   integer seed = 67798;
   int     cycle_cnt = 0;
   int     cycle_limit = 0;

   cl_ddr_stat_top #(
      .NUM_DDR_CH (NUM_CH),
      .CFG_STAGES (8),
      .RST_STAGES (4)
   ) dut0 (
      .clk_main_a0       (clk_main_a0),
      .pipe_rst_n        (pipe_rst_n),
      .sh_ddr_stat_wr    (stat_wr),
      .sh_ddr_stat_rd    (stat_rd),
      .sh_ddr_stat_addr  (stat_addr),
      .sh_ddr_stat_wdata (stat_wdata),
      .ddr_sh_stat_ack   (stat_ack),
      .ddr_sh_stat_rdata (stat_rdata),
      .ddr_sh_stat_int   (stat_int)
   );

   always #20 clk_main_a0 = ~clk_main_a0;

   // Run limit
   always @(posedge clk_main_a0)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
         report_failure($sformatf("Run did not finish within %0d cycles", cycle_limit));
   end

   // -------------------------------------------------------------------------
   // Checking helpers
   // -------------------------------------------------------------------------
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic compare_values(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
      if (actual !== expected)
         report_failure($sformatf("MISMATCH %s actual 0x%08h expected 0x%08h",
                                  name, actual, expected));
   endtask

   task automatic add_entry(input int ch, input logic [1:0] op, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic [7:0] exp_int);
      entry_t e;
      e.ch        = 2'(ch);
      e.op        = op;
      e.addr      = addr;
      e.wdata     = wdata;
      e.exp_rdata = exp_rdata;
      e.exp_int   = exp_int;
      stim_q.push_back(e);
   endtask

   // Pulse one request and count cycles until its ack
   task automatic apply_entry(input entry_t e);
      int ch;
      int n;
      ch = e.ch;
      if (e.op == OP_IDLE)
      begin
         repeat (LATENCY + 3)
         begin
            @(posedge clk_main_a0);
            #1;
            compare_values($sformatf("ddr_sh_stat_ack[%0d]", ch), stat_ack[ch], 32'h0);
         end
      end
      else
      begin
         stat_wr[ch]    = (e.op == OP_WR);
         stat_rd[ch]    = (e.op == OP_RD);
         stat_addr[ch]  = e.addr;
         stat_wdata[ch] = e.wdata;
         for (n = 1; n <= LATENCY; n++)
         begin
            @(posedge clk_main_a0);
            #1;
            stat_wr[ch] = 1'b0;
            stat_rd[ch] = 1'b0;
            if (stat_ack[ch] === 1'b1 && n < LATENCY)
               report_failure($sformatf("Ack on channel %0d came %0d cycles after request, not %0d",
                                        ch, n, LATENCY));
         end
         if (stat_ack[ch] !== 1'b1)
            report_failure($sformatf("No ack on channel %0d %0d cycles after request",
                                     ch, LATENCY));
         compare_values($sformatf("ddr_sh_stat_rdata[%0d]", ch), stat_rdata[ch], e.exp_rdata);
         compare_values($sformatf("ddr_sh_stat_int[%0d]", ch), stat_int[ch], e.exp_int);
      end
   endtask

   // Back-to-back writes and reads to scratch words 0x04 to 0x07 of channel 0
   task automatic run_burst();
      logic [31:0] model [4];
      logic [31:0] exp_q [$];
      logic [31:0] wdata;
      int          slot;
      for (int i = 0; i < 4; i++)
         model[i] = 32'h0;
      for (int cyc = 0; cyc < BURST_LEN + LATENCY + 2; cyc++)
      begin
         if (cyc >= LATENCY && cyc < LATENCY + BURST_LEN)
         begin
            compare_values("ddr_sh_stat_ack[0]", stat_ack[0], 32'h1);
            compare_values("ddr_sh_stat_rdata[0]", stat_rdata[0], exp_q.pop_front());
         end
         else
            compare_values("ddr_sh_stat_ack[0]", stat_ack[0], 32'h0);
         stat_wr[0] = 1'b0;
         stat_rd[0] = 1'b0;
         if (cyc < BURST_LEN)
         begin
            slot = (cyc / 2) % 4;
            if (cyc % 2 == 0)
            begin
               wdata         = $random(seed);
               stat_wr[0]    = 1'b1;
               stat_addr[0]  = 8'(4 + slot);
               stat_wdata[0] = wdata;
               model[slot]   = wdata;
               exp_q.push_back(32'h0);
            end
            else
            begin
               // Read back the word written by the pair before
               slot         = (slot + 3) % 4;
               stat_rd[0]   = 1'b1;
               stat_addr[0] = 8'(4 + slot);
               exp_q.push_back(model[slot]);
            end
         end
         @(posedge clk_main_a0);
         #1;
      end
   endtask

   // -------------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------------
   initial
   begin
      clk_main_a0 = 1'b0;
      pipe_rst_n  = 1'b0;
      stat_wr     = '0;
      stat_rd     = '0;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         stat_addr[ch]  = 8'h0;
         stat_wdata[ch] = 32'h0;
      end

      // Reset values
      add_entry(0, OP_RD, 8'h00, 32'h0, 32'h0, 8'h00);
      add_entry(1, OP_RD, 8'h00, 32'h0, 32'h0, 8'h00);
      add_entry(2, OP_RD, 8'h00, 32'h0, 32'h0, 8'h00);
      // Scratch words kept apart per channel
      add_entry(0, OP_WR, 8'h03, 32'h1111_0003, 32'h0, 8'h00);
      add_entry(1, OP_WR, 8'h03, 32'h2222_0003, 32'h0, 8'h00);
      add_entry(2, OP_WR, 8'h03, 32'h3333_0003, 32'h0, 8'h00);
      add_entry(0, OP_WR, 8'h0F, 32'hA5A5_000F, 32'h0, 8'h00);
      add_entry(0, OP_RD, 8'h03, 32'h0, 32'h1111_0003, 8'h00);
      add_entry(1, OP_RD, 8'h03, 32'h0, 32'h2222_0003, 8'h00);
      add_entry(2, OP_RD, 8'h03, 32'h0, 32'h3333_0003, 8'h00);
      add_entry(0, OP_RD, 8'h0F, 32'h0, 32'hA5A5_000F, 8'h00);
      add_entry(1, OP_RD, 8'h0F, 32'h0, 32'h0, 8'h00);
      // Channel index
      add_entry(0, OP_RD, 8'h10, 32'h0, 32'h0, 8'h00);
      add_entry(1, OP_RD, 8'h10, 32'h0, 32'h1, 8'h00);
      add_entry(2, OP_RD, 8'h10, 32'h0, 32'h2, 8'h00);
      // Unmapped addresses
      add_entry(0, OP_RD, 8'h13, 32'h0, 32'hDEAD_BEEF, 8'h00);
      add_entry(2, OP_RD, 8'hFF, 32'h0, 32'hDEAD_BEEF, 8'h00);
      add_entry(0, OP_WR, 8'h20, 32'hFFFF_FFFF, 32'h0, 8'h00);
      add_entry(0, OP_RD, 8'h00, 32'h0, 32'h0, 8'h00);
      add_entry(1, OP_IDLE, 8'h00, 32'h0, 32'h0, 8'h00);
      // Interrupt set then clear on channel 1
      add_entry(1, OP_WR, 8'h11, 32'h0000_0005, 32'h0, 8'h05);
      add_entry(1, OP_WR, 8'h12, 32'h0000_0001, 32'h0, 8'h04);
      add_entry(1, OP_RD, 8'h11, 32'h0, 32'h0000_0004, 8'h04);
      add_entry(1, OP_RD, 8'h12, 32'h0, 32'h0, 8'h04);

      cycle_limit = (stim_q.size() + BURST_LEN) * 20 + 100;

      repeat (16) @(posedge clk_main_a0);
      #1;
      pipe_rst_n = 1'b1;

      repeat (LATENCY) @(posedge clk_main_a0);
      #1;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         compare_values($sformatf("ddr_sh_stat_ack[%0d]", ch), stat_ack[ch], 32'h0);
         compare_values($sformatf("ddr_sh_stat_int[%0d]", ch), stat_int[ch], 32'h0);
      end

      foreach (stim_q[i])
         apply_entry(stim_q[i]);

      // Interrupt output settles CFG_STAGES cycles after the target
      repeat (8) @(posedge clk_main_a0);
      #1;
      for (int ch = 0; ch < NUM_CH; ch++)
         compare_values($sformatf("ddr_sh_stat_int[%0d]", ch), stat_int[ch],
                        (ch == 1) ? 32'h4 : 32'h0);

      run_burst();

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire
